//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- alu.sv
`timescale 1ns/1ns

module alu (
    input  isa_pkg::word_t   a,
    input  isa_pkg::word_t   b,
    input  isa_pkg::alu_op_e op,
    output isa_pkg::word_t   result
);

    always_comb begin
        case (op)
            isa_pkg::ALU_ADD: result = a + b;
            isa_pkg::ALU_SUB: result = a - b;
            isa_pkg::ALU_AND: result = a & b;
            isa_pkg::ALU_OR:  result = a | b;
            isa_pkg::ALU_NOT: result = ~a;
            isa_pkg::ALU_TCP: result = ~a + isa_pkg::word_t'(1);
            isa_pkg::ALU_SHL: result = a << 1;
            isa_pkg::ALU_SHR: result = isa_pkg::word_t'($signed(a) >>> 1);    // Keeps sign
            isa_pkg::ALU_LHI: result = b << $bits(isa_pkg::imm_t);
            default:          result = a + b;
        endcase
    end

endmodule

//--- compile.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
control_unit.sv
register_file.sv
alu.sv
hazard_unit.sv
cpu.sv
tb_cpu.sv

//--- control_unit.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module control_unit (
    input  isa_pkg::word_t  inst,
    output pipe_pkg::ctrl_t ctrl
);

    isa_pkg::opcode_e opcode;
    isa_pkg::func_e   func;

    assign opcode = isa_pkg::opcode_e'(inst[`OPCODE_MSB:`OPCODE_LSB]);
    assign func   = isa_pkg::func_e'(inst[`FUNC_MSB:`FUNC_LSB]);

    always_comb begin
        ctrl          = '0;                 // Unknown encodings do nothing
        ctrl.dest_sel = pipe_pkg::DEST_RT;
        ctrl.alu_op   = isa_pkg::ALU_ADD;
        case (opcode)
            isa_pkg::OP_BNE, isa_pkg::OP_BEQ,
            isa_pkg::OP_BGZ, isa_pkg::OP_BLZ: ctrl.is_branch = 1'b1;
            isa_pkg::OP_ADI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::OP_ORI: begin
                ctrl.alu_src      = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write    = 1'b1;
                ctrl.alu_op       = isa_pkg::ALU_OR;
            end
            isa_pkg::OP_LHI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = isa_pkg::ALU_LHI;
            end
            isa_pkg::OP_LWD: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::OP_SWD: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            isa_pkg::OP_JMP: ctrl.is_jump = 1'b1;
            isa_pkg::OP_JAL: begin
                ctrl.is_jump   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.pc_to_reg = 1'b1;
                ctrl.dest_sel  = pipe_pkg::DEST_LINK;
            end
            isa_pkg::OP_RTYPE: begin
                ctrl.dest_sel = pipe_pkg::DEST_RD;
                case (func)
                    isa_pkg::FN_WWD: ctrl.wwd  = 1'b1;
                    isa_pkg::FN_HLT: ctrl.halt = 1'b1;
                    isa_pkg::FN_ADD, isa_pkg::FN_SUB, isa_pkg::FN_AND, isa_pkg::FN_ORR,
                    isa_pkg::FN_NOT, isa_pkg::FN_TCP, isa_pkg::FN_SHL,
                    isa_pkg::FN_SHR: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = isa_pkg::alu_op_e'(func[3:0]); // Same order
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- cpu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu (
    input  logic           clk,
    input  logic           reset_n,
    output isa_pkg::word_t inst_addr,
    input  isa_pkg::word_t inst_data,
    output isa_pkg::word_t output_port,
    output logic           output_valid,
    output isa_pkg::word_t num_inst,
    output logic           is_halted
);

    localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

    isa_pkg::word_t     pc, pc_plus1;
    logic               fetch_stop;             // HLT seen in ID
    logic               if_id_valid;
    isa_pkg::word_t     if_id_inst, if_id_pc_next;
    pipe_pkg::id_ex_t   id_ex;
    pipe_pkg::ex_mem_t  ex_mem;
    pipe_pkg::mem_wb_t  mem_wb;
    pipe_pkg::ctrl_t    ctrl;
    pipe_pkg::fwd_sel_e ex_fwd_a, ex_fwd_b, id_fwd_a, id_fwd_b;
    logic               stall, id_go, id_branch, cond, taken, id_halt;
    isa_pkg::reg_addr_t id_rs, id_rt, id_dest;
    isa_pkg::imm_t      id_imm;
    isa_pkg::word_t     rf_a, rf_b, id_a, id_b, imm_ext, br_target, jmp_target;
    isa_pkg::word_t     op_a, op_b, alu_b, alu_result, ex_out, ex_val, mem_val, wb_data;
    isa_pkg::word_t     dmem [`DMEM_DEPTH];

    function automatic isa_pkg::word_t fwd_mux(
        pipe_pkg::fwd_sel_e sel,
        isa_pkg::word_t     reg_val,
        isa_pkg::word_t     near_val,
        isa_pkg::word_t     far_val
    );
        case (sel)
            pipe_pkg::FROM_MEM: return near_val;
            pipe_pkg::FROM_WB:  return far_val;
            default:            return reg_val;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // IF
    assign inst_addr = pc;
    assign pc_plus1  = pc + isa_pkg::word_t'(1);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc          <= '0;
            fetch_stop  <= 1'b0;
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            if_id_valid   <= !(taken || id_halt || fetch_stop);   // Flush slot
            if_id_inst    <= inst_data;
            if_id_pc_next <= pc_plus1;
            if (id_halt) fetch_stop <= 1'b1;
            if (taken) begin
                pc <= ctrl.is_jump ? jmp_target : br_target;
            end else if (!(id_halt || fetch_stop)) begin
                pc <= pc_plus1;     // Predict not taken
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // ID
    assign id_rs     = if_id_inst[`RS_MSB:`RS_LSB];
    assign id_rt     = if_id_inst[`RT_MSB:`RT_LSB];
    assign id_imm    = if_id_inst[`IMM_MSB:`IMM_LSB];
    assign id_go     = if_id_valid & ~stall;
    assign id_branch = if_id_valid & ctrl.is_branch;
    assign id_halt   = id_go & ctrl.halt;

    control_unit u_control_unit (
        .inst (if_id_inst),
        .ctrl (ctrl)
    );

    register_file u_register_file (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_addr_a (id_rs),
        .read_addr_b (id_rt),
        .write_addr  (mem_wb.dest),
        .write_data  (wb_data),
        .write_en    (mem_wb.valid & mem_wb.reg_write),
        .read_data_a (rf_a),
        .read_data_b (rf_b)
    );

    hazard_unit u_hazard_unit (
        .id_rs        (id_rs),
        .id_rt        (id_rt),
        .id_is_branch (id_branch),
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .stall        (stall),
        .ex_fwd_a     (ex_fwd_a),
        .ex_fwd_b     (ex_fwd_b),
        .id_fwd_a     (id_fwd_a),
        .id_fwd_b     (id_fwd_b)
    );

    assign imm_ext = ctrl.imm_zero_ext ? isa_pkg::word_t'(id_imm)
                                       : isa_pkg::word_t'($signed(id_imm));

    always_comb begin
        case (ctrl.dest_sel)
            pipe_pkg::DEST_RT:   id_dest = id_rt;
            pipe_pkg::DEST_LINK: id_dest = isa_pkg::reg_addr_t'(`JAL_LINK_REG);
            default:             id_dest = if_id_inst[`RD_MSB:`RD_LSB];
        endcase
    end

    // Branch compare on forwarded operands
    assign id_a = fwd_mux(id_fwd_a, rf_a, ex_val, mem_val);
    assign id_b = fwd_mux(id_fwd_b, rf_b, ex_val, mem_val);

    always_comb begin
        case (isa_pkg::opcode_e'(if_id_inst[`OPCODE_MSB:`OPCODE_LSB]))
            isa_pkg::OP_BNE: cond = (id_a != id_b);
            isa_pkg::OP_BEQ: cond = (id_a == id_b);
            isa_pkg::OP_BGZ: cond = ($signed(id_a) > 0);
            default:         cond = ($signed(id_a) < 0);   // BLZ
        endcase
    end

    assign taken      = id_go & ((ctrl.is_branch & cond) | ctrl.is_jump);
    assign br_target  = if_id_pc_next + imm_ext;
    assign jmp_target = {if_id_pc_next[`WORD_SIZE-1:`TARGET_MSB+1],
                         if_id_inst[`TARGET_MSB:`TARGET_LSB]};

    always_ff @(posedge clk) begin
        if (reset_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid   <= id_go;     // Bubble on stall
            id_ex.ctrl    <= ctrl;
            id_ex.pc_next <= if_id_pc_next;
            id_ex.rs      <= id_rs;
            id_ex.rt      <= id_rt;
            id_ex.dest    <= id_dest;
            id_ex.read_a  <= rf_a;
            id_ex.read_b  <= rf_b;
            id_ex.imm_ext <= imm_ext;
        end
    end

    ////////////////////////////////////////////////////////////
    // EX
    assign op_a  = fwd_mux(ex_fwd_a, id_ex.read_a, mem_val, wb_data);
    assign op_b  = fwd_mux(ex_fwd_b, id_ex.read_b, mem_val, wb_data);
    assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm_ext : op_b;

    alu u_alu (
        .a      (op_a),
        .b      (alu_b),
        .op     (id_ex.ctrl.alu_op),
        .result (alu_result)
    );

    assign ex_out = id_ex.ctrl.wwd ? op_a : alu_result;              // WWD passes rs
    assign ex_val = id_ex.ctrl.pc_to_reg ? id_ex.pc_next : ex_out;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.pc_to_reg  <= id_ex.ctrl.pc_to_reg;
            ex_mem.wwd        <= id_ex.ctrl.wwd;
            ex_mem.halt       <= id_ex.ctrl.halt;
            ex_mem.dest       <= id_ex.dest;
            ex_mem.alu_out    <= ex_out;
            ex_mem.store_data <= op_b;
            ex_mem.pc_next    <= id_ex.pc_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // MEM
    assign mem_val = ex_mem.pc_to_reg ? ex_mem.pc_next : ex_mem.alu_out;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[ex_mem.alu_out[DMEM_AW-1:0]] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid      <= ex_mem.valid;
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.wwd        <= ex_mem.wwd;
            mem_wb.halt       <= ex_mem.halt;
            mem_wb.pc_to_reg  <= ex_mem.pc_to_reg;
            mem_wb.mem_to_reg <= ex_mem.mem_read;
            mem_wb.dest       <= ex_mem.dest;
            mem_wb.alu_out    <= ex_mem.alu_out;
            mem_wb.mem_data   <= dmem[ex_mem.alu_out[DMEM_AW-1:0]];
            mem_wb.pc_next    <= ex_mem.pc_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // WB
    always_comb begin
        if (mem_wb.mem_to_reg) wb_data = mem_wb.mem_data;
        else if (mem_wb.pc_to_reg) wb_data = mem_wb.pc_next;     // JAL link
        else wb_data = mem_wb.alu_out;
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            output_valid <= 1'b0;
            num_inst     <= '0;
            is_halted    <= 1'b0;
        end else begin
            output_valid <= mem_wb.valid & mem_wb.wwd;
            if (mem_wb.valid && mem_wb.wwd) output_port <= mem_wb.alu_out;
            if (mem_wb.valid) num_inst <= num_inst + isa_pkg::word_t'(1);
            if (mem_wb.valid && mem_wb.halt) is_halted <= 1'b1;
        end
    end

endmodule

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_SIZE       16
`define REG_ADDR_SIZE   2
`define NUM_REGS        4
`define DMEM_DEPTH      256

// Instruction fields
`define OPCODE_MSB      15
`define OPCODE_LSB      12
`define RS_MSB          11
`define RS_LSB          10
`define RT_MSB          9
`define RT_LSB          8
`define RD_MSB          7
`define RD_LSB          6
`define FUNC_MSB        5
`define FUNC_LSB        0
`define IMM_MSB         7
`define IMM_LSB         0
`define TARGET_MSB      11
`define TARGET_LSB      0

`define JAL_LINK_REG    2       // Link register for JAL

`endif

//--- hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
    input  isa_pkg::reg_addr_t id_rs,
    input  isa_pkg::reg_addr_t id_rt,
    input  logic               id_is_branch,
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::ex_mem_t  ex_mem,
    input  pipe_pkg::mem_wb_t  mem_wb,
    output logic               stall,
    output pipe_pkg::fwd_sel_e ex_fwd_a,
    output pipe_pkg::fwd_sel_e ex_fwd_b,
    output pipe_pkg::fwd_sel_e id_fwd_a,
    output pipe_pkg::fwd_sel_e id_fwd_b
);

    logic ex_wr, mem_wr, wb_wr;
    logic ex_load_hit, mem_load_hit;

    // Younger producer wins
    function automatic pipe_pkg::fwd_sel_e pick(
        isa_pkg::reg_addr_t src,
        logic               near_wr,
        isa_pkg::reg_addr_t near_dest,
        logic               far_wr,
        isa_pkg::reg_addr_t far_dest
    );
        if (near_wr && near_dest == src) return pipe_pkg::FROM_MEM;
        if (far_wr && far_dest == src) return pipe_pkg::FROM_WB;
        return pipe_pkg::NONE;
    endfunction

    assign ex_wr  = id_ex.valid & id_ex.ctrl.reg_write;
    assign mem_wr = ex_mem.valid & ex_mem.reg_write;
    assign wb_wr  = mem_wb.valid & mem_wb.reg_write;

    assign ex_load_hit  = id_ex.valid & id_ex.ctrl.mem_read &
                          (id_ex.dest == id_rs || id_ex.dest == id_rt);
    assign mem_load_hit = ex_mem.valid & ex_mem.mem_read &
                          (ex_mem.dest == id_rs || ex_mem.dest == id_rt);
    assign stall = ex_load_hit | (id_is_branch & mem_load_hit);

    assign ex_fwd_a = pick(id_ex.rs, mem_wr, ex_mem.dest, wb_wr, mem_wb.dest);
    assign ex_fwd_b = pick(id_ex.rt, mem_wr, ex_mem.dest, wb_wr, mem_wb.dest);

    // ID selects look one stage earlier
    // FROM_MEM here means the EX result and FROM_WB the MEM result
    assign id_fwd_a = pick(id_rs, ex_wr, id_ex.dest, mem_wr, ex_mem.dest);
    assign id_fwd_b = pick(id_rt, ex_wr, id_ex.dest, mem_wr, ex_mem.dest);

endmodule

//--- isa_pkg.sv
`include "cpu_defines.svh"

package isa_pkg;

    typedef logic [`WORD_SIZE-1:0]           word_t;
    typedef logic [`REG_ADDR_SIZE-1:0]       reg_addr_t;
    typedef logic [`IMM_MSB-`IMM_LSB:0]      imm_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT,
        ALU_TCP, ALU_SHL, ALU_SHR,
        ALU_LHI     // b into the upper byte
    } alu_op_e;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_LINK} dest_sel_e;

    typedef enum logic [1:0] {NONE, FROM_MEM, FROM_WB} fwd_sel_e;

    typedef struct packed {
        logic             alu_src;        // Immediate as operand b
        logic             imm_zero_ext;
        logic             mem_read;
        logic             mem_write;
        logic             reg_write;
        dest_sel_e        dest_sel;
        logic             pc_to_reg;
        logic             is_branch;
        logic             is_jump;
        logic             wwd;
        logic             halt;
        isa_pkg::alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        ctrl_t              ctrl;
        isa_pkg::word_t     pc_next;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     read_a;
        isa_pkg::word_t     read_b;
        isa_pkg::word_t     imm_ext;
    } id_ex_t;

    typedef struct packed {
        logic               valid;
        logic               mem_read;
        logic               mem_write;
        logic               reg_write;
        logic               pc_to_reg;
        logic               wwd;
        logic               halt;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     alu_out;
        isa_pkg::word_t     store_data;
        isa_pkg::word_t     pc_next;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        logic               reg_write;
        logic               wwd;
        logic               halt;
        logic               pc_to_reg;
        logic               mem_to_reg;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     alu_out;
        isa_pkg::word_t     mem_data;
        isa_pkg::word_t     pc_next;
    } mem_wb_t;

endpackage

//--- register_file.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module register_file (
    input  logic               clk,
    input  logic               reset_n,
    input  isa_pkg::reg_addr_t read_addr_a,
    input  isa_pkg::reg_addr_t read_addr_b,
    input  isa_pkg::reg_addr_t write_addr,
    input  isa_pkg::word_t     write_data,
    input  logic               write_en,
    output isa_pkg::word_t     read_data_a,
    output isa_pkg::word_t     read_data_b
);

    isa_pkg::word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // Write-through lets ID see the value retiring in WB
    assign read_data_a = (write_en && write_addr == read_addr_a) ? write_data : regs[read_addr_a];
    assign read_data_b = (write_en && write_addr == read_addr_b) ? write_data : regs[read_addr_b];

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tb_cpu;

    localparam int PROG_LEN       = 64;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 40;
    localparam int RESET_CYCLES   = 10;
    localparam int STIM_DELAY     = 1;
    localparam isa_pkg::word_t LAST_ADDR = isa_pkg::word_t'(PROG_LEN);
    localparam isa_pkg::word_t HALT_WORD = {isa_pkg::OP_RTYPE, 6'd0, isa_pkg::FN_HLT};

    logic           clk;
    logic           reset_n;
    isa_pkg::word_t inst_addr;
    isa_pkg::word_t inst_data;
    isa_pkg::word_t output_port;
    logic           output_valid;
    isa_pkg::word_t num_inst;
    logic           is_halted;

    isa_pkg::word_t prog [0:PROG_LEN];
    isa_pkg::word_t lfsr;
    isa_pkg::word_t exp_wwd [$];
    int             exp_retired;
    int             wwd_seen;
    int             cycles;

    cpu u_cpu (
        .clk          (clk),
        .reset_n      (reset_n),
        .inst_addr    (inst_addr),
        .inst_data    (inst_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    always #50 clk = ~clk;

    // Fetch past the end of the program reads HLT
    assign inst_data = (inst_addr <= LAST_ADDR) ? prog[inst_addr] : HALT_WORD;

    ////////////////////////////////////////////////////////////
    // Random program

    function automatic isa_pkg::word_t lfsr_shift(isa_pkg::word_t s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // Taps 16 14 13 11
    endfunction

    function automatic int unsigned take_random_bits(int n);
        int unsigned v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_shift(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic isa_pkg::word_t encode_r(isa_pkg::func_e fn, isa_pkg::reg_addr_t rs,
                                                isa_pkg::reg_addr_t rt, isa_pkg::reg_addr_t rd);
        return {isa_pkg::OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic isa_pkg::word_t encode_i(isa_pkg::opcode_e op, isa_pkg::reg_addr_t rs,
                                                isa_pkg::reg_addr_t rt, isa_pkg::imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic build_program();
        int unsigned        kind;
        isa_pkg::reg_addr_t rs, rt, rd, st_base;
        isa_pkg::imm_t      st_off;
        logic [11:0]        target;
        logic               room;
        st_base = '0;
        st_off  = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = take_random_bits(4);
            rs   = isa_pkg::reg_addr_t'(take_random_bits(2));
            rt   = isa_pkg::reg_addr_t'(take_random_bits(2));
            rd   = isa_pkg::reg_addr_t'(take_random_bits(2));
            room = (i + 5 <= PROG_LEN);             // Forward skip of up to 4 fits
            if (kind < 4) begin
                prog[i] = encode_r(isa_pkg::func_e'(take_random_bits(3)), rs, rt, rd);
            end else if (kind < 7 || (kind >= 12 && !room)) begin
                prog[i] = encode_r(isa_pkg::FN_WWD, rs, rt, rd);
            end else if (kind == 7) begin
                prog[i] = encode_i(isa_pkg::OP_ADI, rs, rt, isa_pkg::imm_t'(take_random_bits(8)));
            end else if (kind == 8) begin
                prog[i] = encode_i(isa_pkg::OP_ORI, rs, rt, isa_pkg::imm_t'(take_random_bits(8)));
            end else if (kind == 9) begin
                prog[i] = encode_i(isa_pkg::OP_LHI, rs, rt, isa_pkg::imm_t'(take_random_bits(8)));
            end else if (kind == 10) begin
                st_base = rs;
                st_off  = isa_pkg::imm_t'(take_random_bits(3));
                prog[i] = encode_i(isa_pkg::OP_SWD, rs, rt, st_off);
            end else if (kind == 11) begin
                // Half the loads reuse the base and offset of the last store
                if (take_random_bits(1) == 1) begin
                    prog[i] = encode_i(isa_pkg::OP_LWD, st_base, rt, st_off);
                end else begin
                    prog[i] = encode_i(isa_pkg::OP_LWD, rs, rt,
                                       isa_pkg::imm_t'(take_random_bits(3)));
                end
            end else if (kind < 14) begin
                prog[i] = encode_i(isa_pkg::opcode_e'(take_random_bits(2)), rs, rt,
                                   isa_pkg::imm_t'(1 + take_random_bits(2)));
            end else begin
                target  = 12'(i + 2 + int'(take_random_bits(2)));
                prog[i] = {(kind == 14) ? isa_pkg::OP_JMP : isa_pkg::OP_JAL, target};
            end
        end
        prog[PROG_LEN] = HALT_WORD;
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model stepping one instruction at a time

    task automatic run_reference();
        isa_pkg::word_t     regs [`NUM_REGS];
        isa_pkg::word_t     mem [`DMEM_DEPTH];
        isa_pkg::word_t     pc, inst, a, b, imm_s, addr;
        isa_pkg::reg_addr_t rs, rt, rd;
        logic               done;
        for (int r = 0; r < `NUM_REGS; r++) regs[r] = '0;
        for (int m = 0; m < `DMEM_DEPTH; m++) mem[m] = '0;
        pc          = '0;
        done        = 1'b0;
        exp_retired = 0;
        while (!done) begin
            inst  = (pc <= LAST_ADDR) ? prog[pc] : HALT_WORD;
            rs    = inst[`RS_MSB:`RS_LSB];
            rt    = inst[`RT_MSB:`RT_LSB];
            rd    = inst[`RD_MSB:`RD_LSB];
            a     = regs[rs];
            b     = regs[rt];
            imm_s = {{8{inst[7]}}, inst[7:0]};
            addr  = a + imm_s;
            exp_retired++;
            pc = pc + 16'd1;
            case (isa_pkg::opcode_e'(inst[`OPCODE_MSB:`OPCODE_LSB]))
                isa_pkg::OP_BNE: if (a != b) pc = pc + imm_s;
                isa_pkg::OP_BEQ: if (a == b) pc = pc + imm_s;
                isa_pkg::OP_BGZ: if (!a[15] && a != 16'd0) pc = pc + imm_s;
                isa_pkg::OP_BLZ: if (a[15]) pc = pc + imm_s;
                isa_pkg::OP_ADI: regs[rt] = addr;
                isa_pkg::OP_ORI: regs[rt] = a | {8'd0, inst[7:0]};
                isa_pkg::OP_LHI: regs[rt] = {inst[7:0], 8'd0};
                isa_pkg::OP_LWD: regs[rt] = mem[addr[7:0]];
                isa_pkg::OP_SWD: mem[addr[7:0]] = b;
                isa_pkg::OP_JMP: pc = {pc[15:12], inst[11:0]};
                isa_pkg::OP_JAL: begin
                    regs[`JAL_LINK_REG] = pc;       // Link is PC+1
                    pc = {pc[15:12], inst[11:0]};
                end
                isa_pkg::OP_RTYPE: begin
                    case (isa_pkg::func_e'(inst[`FUNC_MSB:`FUNC_LSB]))
                        isa_pkg::FN_ADD: regs[rd] = a + b;
                        isa_pkg::FN_SUB: regs[rd] = a - b;
                        isa_pkg::FN_AND: regs[rd] = a & b;
                        isa_pkg::FN_ORR: regs[rd] = a | b;
                        isa_pkg::FN_NOT: regs[rd] = ~a;
                        isa_pkg::FN_TCP: regs[rd] = 16'd0 - a;
                        isa_pkg::FN_SHL: regs[rd] = {a[14:0], 1'b0};
                        isa_pkg::FN_SHR: regs[rd] = {a[15], a[15:1]};
                        isa_pkg::FN_WWD: exp_wwd.push_back(a);
                        isa_pkg::FN_HLT: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checks

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, isa_pkg::word_t got, isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic take_wwd();
        if (wwd_seen >= exp_wwd.size()) begin
            $display("output_valid pulsed at %0t ns with no WWD left in the model", $time);
            stop_on_error();
        end else begin
            check_word("output_port", output_port, exp_wwd[wwd_seen]);
            wwd_seen++;
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset_n  = 1'b1;
        lfsr     = 16'd17;
        wwd_seen = 0;
        cycles   = 0;
        build_program();
        run_reference();

        repeat (RESET_CYCLES) @(posedge clk);
        #STIM_DELAY reset_n = 1'b0;

        @(negedge clk);         // Nothing retired yet
        check_flag("output_valid", output_valid, 1'b0);
        check_flag("is_halted", is_halted, 1'b0);
        check_word("num_inst", num_inst, 16'd0);

        while (!is_halted) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles, the core never halted", cycles);
                stop_on_error();
            end
            if (output_valid) take_wwd();
        end

        check_word("num_inst", num_inst, isa_pkg::word_t'(exp_retired));
        check_word("wwd_count", isa_pkg::word_t'(wwd_seen), isa_pkg::word_t'(exp_wwd.size()));

        // Halted core stays quiet
        repeat (8) begin
            @(negedge clk);
            check_flag("output_valid", output_valid, 1'b0);
            check_flag("is_halted", is_halted, 1'b1);
            check_word("num_inst", num_inst, isa_pkg::word_t'(exp_retired));
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
